//--- tb.f
+incdir+rtl
rtl/f2h_uart_pkg.sv
rtl/key_debounce.sv
rtl/axi_read_master.sv
rtl/axi_write_master.sv
rtl/uart_port.sv
rtl/msg_sequencer.sv
rtl/f2h_uart_top.sv
verification/tb_f2h_uart.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_f2h_uart \
	-f tb.f -o tb_f2h_uart &&
./obj_dir/tb_f2h_uart | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }

//--- verification/tb_f2h_uart.sv
/* Testbench for the FPGA-to-HPS UART message path
   Models HPS UART0 behind the AXI bridge and checks every console message */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module tb_f2h_uart;
	import f2h_uart_pkg::*;

	localparam int STABLE_CYCLES   = 4;
	localparam int HANDSHAKE_LIMIT = 50;
	localparam int MSG_LIMIT       = 20000;
	localparam logic [31:0] THR_ADDR  = `UART_BASE_ADDR + `UART_THR_OFS;
	localparam logic [31:0] LSR_ADDR  = `UART_BASE_ADDR + `UART_LSR_OFS;
	// Busy LSR has every other status bit set
	localparam logic [31:0] LSR_BUSY  = ~(32'h1 << `LSR_THRE_BIT);
	localparam logic [31:0] LSR_READY = 32'h1 << `LSR_THRE_BIT;

	typedef struct packed {
		logic [31:0] ver;
		logic [3:0]  lsr_busy;
		logic [3:0]  glitch;
		logic [7:0]  press;
		logic        repress;
	} row_t;

	logic    FPGA_CLK1_50;
	logic    my_reset;
	logic    key_n;
	logic    led;
	logic    aw_valid;
	logic    aw_ready;
	axi_aw_t aw;
	logic    w_valid;
	logic    w_ready;
	axi_w_t  w;
	logic    b_valid;
	logic    b_ready;
	axi_b_t  b;
	logic    ar_valid;
	logic    ar_ready;
	axi_ar_t ar;
	logic    r_valid;
	logic    r_ready;
	axi_r_t  r;

	row_t        rows [4];
	logic [7:0]  exp_q [$];
	logic [7:0]  thr_log [$];
	int          fetch_at;
	logic [31:0] cur_ver;
	int          cur_busy;
	int          stall_left;
	int          lsr_since_write;
	logic        thre_seen;
	int          ver_reads;
	int          bus_ops;
	int          err_cnt;
	int          tmo_cnt;

	f2h_uart_top #(
		.STABLE_CYCLES(STABLE_CYCLES)
	) i_dut (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.key_n        (key_n),
		.led          (led),
		.aw_valid     (aw_valid),
		.aw_ready     (aw_ready),
		.aw           (aw),
		.w_valid      (w_valid),
		.w_ready      (w_ready),
		.w            (w),
		.b_valid      (b_valid),
		.b_ready      (b_ready),
		.b            (b),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.ar           (ar),
		.r_valid      (r_valid),
		.r_ready      (r_ready),
		.r            (r)
	);

	always #5 FPGA_CLK1_50 = ~FPGA_CLK1_50;

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------
	task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(string what, logic [`F2H_DATA_W-1:0] got,
		logic [`F2H_DATA_W-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_beat(string what, axi_aw_t got, axi_aw_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_data_beat(string what, axi_w_t got, axi_w_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic note_timeout(string what);
		tmo_cnt++;
		$display("Timed out waiting for %s at %0t", what, $time);
	endtask

	// ------------------------------------------------------------------
	// Timing helpers and expected message
	// ------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge FPGA_CLK1_50);
		#1;
	endtask

	task automatic random_stall();
		repeat ($urandom_range(3, 0))
			next_cycle();
	endtask

	task automatic hold_key(int cycles);
		key_n = 1'b0;
		repeat (cycles)
			next_cycle();
		key_n = 1'b1;
	endtask

	task automatic idle_check(int cycles);
		repeat (cycles) begin
			next_cycle();
			check_byte("valid and ready bits while idle",
				{3'b0, aw_valid, w_valid, ar_valid, b_ready, r_ready}, 8'h00);
			check_byte("led while idle", {7'b0, led}, 8'h00);
		end
	endtask

	function automatic logic [7:0] hex_digit(logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		else
			return 8'h41 + {4'h0, nib} - 8'd10;
	endfunction

	function automatic void build_expected(logic [31:0] ver);
		string greet  = "Hello from the FPGA side";
		string prefix = "0xFFC020F8: ";
		exp_q.delete();
		for (int i = 0; i < greet.len(); i++)
			exp_q.push_back(greet[i]);
		exp_q.push_back(8'h0D);
		exp_q.push_back(8'h0A);
		for (int i = 0; i < prefix.len(); i++)
			exp_q.push_back(prefix[i]);
		// Version fetch comes right after the prefix
		fetch_at = exp_q.size();
		for (int i = 7; i >= 0; i--)
			exp_q.push_back(hex_digit(ver[4*i +: 4]));
		exp_q.push_back(8'h0D);
		exp_q.push_back(8'h0A);
	endfunction

	// ------------------------------------------------------------------
	// HPS UART0 slave model
	// ------------------------------------------------------------------
	task automatic serve_read();
		axi_ar_t     req_q;
		axi_ar_t     beat_exp;
		logic [31:0] exp_addr;
		logic [31:0] rdata;
		int          n;
		req_q    = ar;
		bus_ops++;
		exp_addr = (thr_log.size() == fetch_at && ver_reads == 0) ? `UART_VER_ADDR : LSR_ADDR;
		beat_exp = '{addr: req_q.addr, len: 4'd0, size: `AXI_SIZE_WORD,
			burst: `AXI_BURST_INCR, prot: 3'd0};
		check_word("read address", req_q.addr, exp_addr);
		check_beat("read address beat", req_q, beat_exp);
		random_stall();
		ar_ready = 1'b1;
		next_cycle();
		ar_ready = 1'b0;
		if (req_q.addr == `UART_VER_ADDR) begin
			ver_reads++;
			rdata = cur_ver;
		end else if (stall_left > 0) begin
			stall_left--;
			lsr_since_write++;
			thre_seen = 1'b0;
			rdata     = LSR_BUSY;
		end else begin
			lsr_since_write++;
			thre_seen = 1'b1;
			rdata     = LSR_READY;
		end
		random_stall();
		r       = '{data: rdata, resp: 2'b00, last: 1'b1};
		r_valid = 1'b1;
		n = 0;
		while (!r_ready && n < HANDSHAKE_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!r_ready)
			note_timeout("r_ready");
		next_cycle();
		r_valid = 1'b0;
	endtask

	task automatic serve_write();
		axi_aw_t aw_q;
		axi_aw_t aw_exp;
		axi_w_t  w_q;
		axi_w_t  w_exp;
		int      n;
		aw_q   = aw;
		w_q    = w;
		bus_ops++;
		aw_exp = '{addr: THR_ADDR, len: 4'd0, size: `AXI_SIZE_WORD,
			burst: `AXI_BURST_INCR, prot: 3'd0};
		// Upper lanes stay zero
		// The byte itself goes to the THR log
		w_exp  = '{data: {24'h0, w_q.data[7:0]}, strb: 4'b0001, last: 1'b1};
		check_beat("write address beat", aw_q, aw_exp);
		check_data_beat("write data beat", w_q, w_exp);
		check_word("LSR reads before THR write", lsr_since_write,
			(thr_log.size() == 0) ? cur_busy + 1 : 1);
		check_byte("THRE before THR write", {7'b0, thre_seen}, 8'h01);
		random_stall();
		aw_ready = 1'b1;
		next_cycle();
		aw_ready = 1'b0;
		n = 0;
		while (!w_valid && n < HANDSHAKE_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!w_valid)
			note_timeout("w_valid");
		random_stall();
		w_ready = 1'b1;
		next_cycle();
		w_ready = 1'b0;
		random_stall();
		b       = '{resp: 2'b00};
		b_valid = 1'b1;
		n = 0;
		while (!b_ready && n < HANDSHAKE_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!b_ready)
			note_timeout("b_ready");
		next_cycle();
		b_valid = 1'b0;
		thr_log.push_back(w_q.data[7:0]);
		lsr_since_write = 0;
		thre_seen       = 1'b0;
	endtask

	always begin
		next_cycle();
		if (!my_reset) begin
			if (ar_valid)
				serve_read();
			else if (aw_valid || w_valid)
				serve_write();
		end
	end

	// ------------------------------------------------------------------
	// One table row with glitch, press, message and idle checks
	// ------------------------------------------------------------------
	task automatic run_row(row_t rw);
		int ops_before;
		int n;
		cur_ver         = rw.ver;
		cur_busy        = int'(rw.lsr_busy);
		stall_left      = int'(rw.lsr_busy);
		lsr_since_write = 0;
		thre_seen       = 1'b0;
		ver_reads       = 0;
		thr_log.delete();
		build_expected(rw.ver);

		ops_before = bus_ops;
		if (rw.glitch != 4'd0)
			hold_key(int'(rw.glitch));
		idle_check(20);
		check_word("bus transfers after glitch", bus_ops, ops_before);

		hold_key(int'(rw.press));
		n = 0;
		while (thr_log.size() == 0 && n < MSG_LIMIT) begin
			next_cycle();
			n++;
		end
		if (thr_log.size() == 0)
			note_timeout("the first THR byte");
		// Second press lands in the middle of the message
		if (rw.repress)
			hold_key(int'(rw.press));
		n = 0;
		while (thr_log.size() < exp_q.size() && n < MSG_LIMIT) begin
			next_cycle();
			n++;
		end
		if (thr_log.size() < exp_q.size())
			note_timeout("the end of the message");
		idle_check(60);

		check_word("THR byte count", thr_log.size(), exp_q.size());
		foreach (exp_q[i])
			if (i < thr_log.size())
				check_byte($sformatf("THR byte %0d", i), thr_log[i], exp_q[i]);
		check_word("version register reads", ver_reads, 1);
	endtask

	initial begin
		FPGA_CLK1_50 = 1'b0;
		my_reset     = 1'b1;
		key_n        = 1'b1;
		aw_ready     = 1'b0;
		w_ready      = 1'b0;
		b_valid      = 1'b0;
		b            = '0;
		ar_ready     = 1'b0;
		r_valid      = 1'b0;
		r            = '0;
		thre_seen    = 1'b0;
		err_cnt      = 0;
		tmo_cnt      = 0;
		bus_ops      = 0;
		fetch_at     = 0;
		void'($urandom(32'he6a5_29bf));

		rows[0] = '{ver: 32'h3331_2A0A, lsr_busy: 4'd0, glitch: 4'd1, press: 8'd6, repress: 1'b0};
		rows[1] = '{ver: 32'h89AB_CDEF, lsr_busy: 4'd3, glitch: 4'd2, press: 8'd10, repress: 1'b1};
		rows[2] = '{ver: 32'h0123_4567, lsr_busy: 4'd1, glitch: 4'd3, press: 8'd5, repress: 1'b0};
		rows[3] = '{ver: 32'hFEDC_BA90, lsr_busy: 4'd7, glitch: 4'd0, press: 8'd16, repress: 1'b1};

		repeat (2)
			@(posedge FPGA_CLK1_50);
		#1;
		my_reset = 1'b0;
		idle_check(5);

		foreach (rows[i])
			run_row(rows[i]);

		$display("Errors: %0d value mismatches, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/f2h_uart_top.sv
/* FPGA-to-HPS UART message top level
   Key debouncer, message sequencer, UART port and the two AXI masters */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module f2h_uart_top #(
	parameter int STABLE_CYCLES = 1_000_000
) (
	input  wire logic                     FPGA_CLK1_50,
	input  wire logic                     my_reset,
	input  wire logic                     key_n,
	output logic                          led,
	output logic                          aw_valid,
	input  wire logic                     aw_ready,
	output f2h_uart_pkg::axi_aw_t         aw,
	output logic                          w_valid,
	input  wire logic                     w_ready,
	output f2h_uart_pkg::axi_w_t          w,
	input  wire logic                     b_valid,
	output logic                          b_ready,
	input  wire f2h_uart_pkg::axi_b_t     b,
	output logic                          ar_valid,
	input  wire logic                     ar_ready,
	output f2h_uart_pkg::axi_ar_t         ar,
	input  wire logic                     r_valid,
	output logic                          r_ready,
	input  wire f2h_uart_pkg::axi_r_t     r
);
	import f2h_uart_pkg::*;

	logic                   pressed;
	logic                   req_valid;
	port_req_t              req;
	logic                   req_done;
	logic [`F2H_DATA_W-1:0] word;
	logic                   rd_start;
	logic [`F2H_ADDR_W-1:0] rd_addr;
	logic                   rd_done;
	bus_word_u              rd_data;
	logic                   wr_start;
	logic [`F2H_ADDR_W-1:0] wr_addr;
	logic [7:0]             wr_byte;
	logic [1:0]             wr_lane;
	logic                   wr_done;

	assign led = pressed;

	key_debounce #(
		.STABLE_CYCLES(STABLE_CYCLES)
	) i_debounce (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.key_n        (key_n),
		.pressed      (pressed)
	);

	msg_sequencer i_sequencer (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.pressed      (pressed),
		.req_valid    (req_valid),
		.req          (req),
		.req_done     (req_done),
		.word_in      (word)
	);

	uart_port i_port (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.req_valid    (req_valid),
		.req          (req),
		.req_done     (req_done),
		.word_out     (word),
		.rd_start     (rd_start),
		.rd_addr      (rd_addr),
		.rd_done      (rd_done),
		.rd_data      (rd_data),
		.wr_start     (wr_start),
		.wr_addr      (wr_addr),
		.wr_byte      (wr_byte),
		.wr_lane      (wr_lane),
		.wr_done      (wr_done)
	);

	// ------------------------------------------------------------------
	// Bridge masters
	// ------------------------------------------------------------------
	axi_read_master i_rd_master (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.rd_start     (rd_start),
		.rd_addr      (rd_addr),
		.rd_done      (rd_done),
		.rd_data      (rd_data),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.ar           (ar),
		.r_valid      (r_valid),
		.r_ready      (r_ready),
		.r            (r)
	);

	axi_write_master i_wr_master (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.my_reset     (my_reset),
		.wr_start     (wr_start),
		.wr_addr      (wr_addr),
		.wr_byte      (wr_byte),
		.wr_lane      (wr_lane),
		.wr_done      (wr_done),
		.aw_valid     (aw_valid),
		.aw_ready     (aw_ready),
		.aw           (aw),
		.w_valid      (w_valid),
		.w_ready      (w_ready),
		.w            (w),
		.b_valid      (b_valid),
		.b_ready      (b_ready),
		.b            (b)
	);

endmodule

`default_nettype wire

//--- rtl/msg_sequencer.sv
/* Console message sequencer
   After a press and release, sends greeting, prefix, version word in hex and CR LF */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module msg_sequencer (
	input  wire logic                     FPGA_CLK1_50,
	input  wire logic                     my_reset,
	input  wire logic                     pressed,
	output logic                          req_valid,
	output f2h_uart_pkg::port_req_t       req,
	input  wire logic                     req_done,
	input  wire logic [`F2H_DATA_W-1:0]   word_in
);
	import f2h_uart_pkg::*;

	localparam int GREET_LEN  = 26;
	localparam int PREFIX_LEN = 12;
	localparam logic [8*GREET_LEN-1:0]  GREET_MSG  = "Hello from the FPGA side\r\n";
	localparam logic [8*PREFIX_LEN-1:0] PREFIX_MSG = "0xFFC020F8: ";

	typedef enum logic [2:0] {
		ST_IDLE, ST_RELEASE, ST_GREET, ST_PREFIX, ST_FETCH, ST_HEX, ST_CR, ST_LF
	} state_t;

	state_t                 state;
	logic [4:0]             idx;
	logic                   busy;
	logic                   issue;
	logic [7:0]             tx_byte;
	logic [3:0]             nibble;
	logic [`F2H_DATA_W-1:0] ver_q;

	assign issue  = !busy && state != ST_IDLE && state != ST_RELEASE;
	assign nibble = ver_q[`F2H_DATA_W-1 -: 4];

	// ------------------------------------------------------------------
	// Byte for the current position, strings are stored first char high
	// ------------------------------------------------------------------
	always_comb begin
		case (state)
			ST_GREET:  tx_byte = GREET_MSG[8*(GREET_LEN-1-int'(idx)) +: 8];
			ST_PREFIX: tx_byte = PREFIX_MSG[8*(PREFIX_LEN-1-int'(idx)) +: 8];
			ST_HEX:    tx_byte = (nibble < 4'd10) ? 8'h30 + 8'(nibble) : 8'h37 + 8'(nibble);
			ST_CR:     tx_byte = 8'h0D;
			ST_LF:     tx_byte = 8'h0A;
			default:   tx_byte = 8'h00;
		endcase
	end

	// ------------------------------------------------------------------
	// Control FSM, one request in flight at a time
	// ------------------------------------------------------------------
	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state     <= ST_IDLE;
			idx       <= '0;
			busy      <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				ST_IDLE: if (pressed)
					state <= ST_RELEASE;
				ST_RELEASE: if (!pressed) begin
					idx   <= '0;
					state <= ST_GREET;
				end
				default: begin
					if (issue) begin
						req_valid <= 1'b1;
						busy      <= 1'b1;
					end else if (req_done) begin
						busy <= 1'b0;
						idx  <= idx + 1'b1;
						case (state)
							ST_GREET: if (idx == 5'(GREET_LEN - 1)) begin
								idx   <= '0;
								state <= ST_PREFIX;
							end
							ST_PREFIX: if (idx == 5'(PREFIX_LEN - 1)) begin
								idx   <= '0;
								state <= ST_FETCH;
							end
							ST_FETCH: begin
								idx   <= '0;
								state <= ST_HEX;
							end
							ST_HEX: if (idx == 5'd7)
								state <= ST_CR;
							ST_CR: state <= ST_LF;
							default: state <= ST_IDLE;
						endcase
					end
				end
			endcase
		end
	end

	always_ff @(posedge FPGA_CLK1_50) begin
		if (issue) begin
			req.kind    <= (state == ST_FETCH) ? PORT_FETCH_WORD : PORT_SEND_BYTE;
			req.tx_byte <= tx_byte;
			req.addr    <= `UART_VER_ADDR;
		end
		// Version word, shifted out most significant nibble first
		if (busy && req_done) begin
			if (state == ST_FETCH)
				ver_q <= word_in;
			else if (state == ST_HEX)
				ver_q <= ver_q << 4;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_port.sv
/* HPS UART0 access port
   Sends one byte after polling LSR for THRE, or fetches one word over the bridge */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module uart_port (
	input  wire logic                     FPGA_CLK1_50,
	input  wire logic                     my_reset,
	input  wire logic                     req_valid,
	input  wire f2h_uart_pkg::port_req_t  req,
	output logic                          req_done,
	output logic [`F2H_DATA_W-1:0]        word_out,
	output logic                          rd_start,
	output logic [`F2H_ADDR_W-1:0]        rd_addr,
	input  wire logic                     rd_done,
	input  wire f2h_uart_pkg::bus_word_u  rd_data,
	output logic                          wr_start,
	output logic [`F2H_ADDR_W-1:0]        wr_addr,
	output logic [7:0]                    wr_byte,
	output logic [1:0]                    wr_lane,
	input  wire logic                     wr_done
);
	import f2h_uart_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_POLL, ST_WRITE, ST_FETCH} state_t;

	state_t    state;
	port_req_t req_q;

	// THR is byte wide and sits in lane 0
	assign wr_addr = `UART_BASE_ADDR + `UART_THR_OFS;
	assign wr_lane = 2'd0;
	assign wr_byte = req_q.tx_byte;
	assign rd_addr = (req_q.kind == PORT_SEND_BYTE) ?
		`UART_BASE_ADDR + `UART_LSR_OFS : req_q.addr;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state    <= ST_IDLE;
			rd_start <= 1'b0;
			wr_start <= 1'b0;
			req_done <= 1'b0;
		end else begin
			rd_start <= 1'b0;
			wr_start <= 1'b0;
			req_done <= 1'b0;
			case (state)
				ST_IDLE: if (req_valid) begin
					rd_start <= 1'b1;
					state    <= (req.kind == PORT_SEND_BYTE) ? ST_POLL : ST_FETCH;
				end
				ST_POLL: if (rd_done) begin
					// Read LSR again until the holding register is empty
					if (rd_data.lsr.thre) begin
						wr_start <= 1'b1;
						state    <= ST_WRITE;
					end else begin
						rd_start <= 1'b1;
					end
				end
				ST_WRITE: if (wr_done) begin
					req_done <= 1'b1;
					state    <= ST_IDLE;
				end
				default: if (rd_done) begin
					req_done <= 1'b1;
					state    <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge FPGA_CLK1_50) begin
		if (state == ST_IDLE && req_valid)
			req_q <= req;
		if (state == ST_FETCH && rd_done)
			word_out <= rd_data.raw;
	end

	a_one_req: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		state != ST_IDLE |-> !req_valid)
		else $error("New request while the port is busy");

endmodule

`default_nettype wire

//--- rtl/axi_write_master.sv
/* AXI single-beat write master
   Places one byte in its lane, sets the strobe and waits for the response */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module axi_write_master (
	input  wire logic                     FPGA_CLK1_50,
	input  wire logic                     my_reset,
	input  wire logic                     wr_start,
	input  wire logic [`F2H_ADDR_W-1:0]   wr_addr,
	input  wire logic [7:0]               wr_byte,
	input  wire logic [1:0]               wr_lane,
	output logic                          wr_done,
	output logic                          aw_valid,
	input  wire logic                     aw_ready,
	output f2h_uart_pkg::axi_aw_t         aw,
	output logic                          w_valid,
	input  wire logic                     w_ready,
	output f2h_uart_pkg::axi_w_t          w,
	input  wire logic                     b_valid,
	output logic                          b_ready,
	input  wire f2h_uart_pkg::axi_b_t     b
);
	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_RESP} state_t;

	state_t state;
	logic   aw_left;
	logic   w_left;

	// Channels still waiting for their handshake after this cycle
	assign aw_left = aw_valid && !aw_ready;
	assign w_left  = w_valid && !w_ready;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state    <= ST_IDLE;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
			b_ready  <= 1'b0;
			wr_done  <= 1'b0;
		end else begin
			wr_done <= 1'b0;
			case (state)
				ST_IDLE: if (wr_start) begin
					aw_valid <= 1'b1;
					w_valid  <= 1'b1;
					state    <= ST_SEND;
				end
				ST_SEND: begin
					aw_valid <= aw_left;
					w_valid  <= w_left;
					if (!aw_left && !w_left) begin
						b_ready <= 1'b1;
						state   <= ST_RESP;
					end
				end
				default: if (b_valid) begin
					b_ready <= 1'b0;
					wr_done <= 1'b1;
					state   <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge FPGA_CLK1_50) begin
		if (state == ST_IDLE && wr_start) begin
			aw <= '{addr: wr_addr, len: 4'd0, size: `AXI_SIZE_WORD,
				burst: `AXI_BURST_INCR, prot: 3'd0};
			w  <= '{data: `F2H_DATA_W'(wr_byte) << {wr_lane, 3'b000},
				strb: 4'b0001 << wr_lane, last: 1'b1};
		end
	end

	a_aw_stable: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else $error("AW channel changed under back-pressure");

	a_w_stable: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else $error("W channel changed under back-pressure");

	// UART registers on the bridge always answer OKAY
	a_b_okay: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		b_valid && b_ready |-> b.resp == 2'b00)
		else $error("Write response not OKAY");

endmodule

`default_nettype wire

//--- rtl/axi_read_master.sv
/* AXI single-beat read master
   One read address per start pulse, the returned word is held until the next start */
`timescale 1ns/100ps
`default_nettype none
`include "f2h_uart_settings.svh"

module axi_read_master (
	input  wire logic                     FPGA_CLK1_50,
	input  wire logic                     my_reset,
	input  wire logic                     rd_start,
	input  wire logic [`F2H_ADDR_W-1:0]   rd_addr,
	output logic                          rd_done,
	output f2h_uart_pkg::bus_word_u       rd_data,
	output logic                          ar_valid,
	input  wire logic                     ar_ready,
	output f2h_uart_pkg::axi_ar_t         ar,
	input  wire logic                     r_valid,
	output logic                          r_ready,
	input  wire f2h_uart_pkg::axi_r_t     r
);
	logic idle;

	assign idle = !ar_valid && !r_ready;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			ar_valid <= 1'b0;
			r_ready  <= 1'b0;
			rd_done  <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			if (rd_start && idle) begin
				ar_valid <= 1'b1;
				r_ready  <= 1'b1;
			end
			if (ar_valid && ar_ready)
				ar_valid <= 1'b0;
			if (r_valid && r_ready) begin
				r_ready <= 1'b0;
				rd_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge FPGA_CLK1_50) begin
		if (rd_start && idle)
			ar <= '{addr: rd_addr, len: 4'd0, size: `AXI_SIZE_WORD,
				burst: `AXI_BURST_INCR, prot: 3'd0};
		if (r_valid && r_ready)
			rd_data.raw <= r.data;
	end

	a_ar_stable: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("AR channel changed under back-pressure");

	// The bridge must end every read after one beat
	a_r_single: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		r_valid && r_ready |-> r.last)
		else $error("Read data without last flag");

endmodule

`default_nettype wire

//--- rtl/key_debounce.sv
/* Push button debouncer
   Synchronizes the active-low key and outputs a clean pressed level */
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
	parameter int STABLE_CYCLES = 1_000_000
) (
	input  wire logic FPGA_CLK1_50,
	input  wire logic my_reset,
	input  wire logic key_n,
	output logic      pressed
);
	localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

	logic [1:0]       sync;
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			sync       <= 2'b00;
			stable_cnt <= '0;
			pressed    <= 1'b0;
		end else begin
			sync <= {sync[0], ~key_n};
			// Count only while the synchronized key disagrees with the output
			if (sync[1] == pressed) begin
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(STABLE_CYCLES - 1)) begin
				stable_cnt <= '0;
				pressed    <= sync[1];
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/f2h_uart_pkg.sv
/* Shared types of the FPGA-to-HPS UART path
   AXI channel payloads, UART port requests and the decoded bus word */
`default_nettype none
`include "f2h_uart_settings.svh"

package f2h_uart_pkg;

	// AXI channel payloads, single beat, no IDs or user bits
	typedef struct packed {
		logic [`F2H_ADDR_W-1:0] addr;
		logic [3:0]             len;
		logic [2:0]             size;
		logic [1:0]             burst;
		logic [2:0]             prot;
	} axi_aw_t;

	typedef axi_aw_t axi_ar_t;

	typedef struct packed {
		logic [`F2H_DATA_W-1:0] data;
		logic [3:0]             strb;
		logic                   last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	typedef struct packed {
		logic [`F2H_DATA_W-1:0] data;
		logic [1:0]             resp;
		logic                   last;
	} axi_r_t;

	// Work items handed to the UART port
	typedef enum logic {PORT_SEND_BYTE, PORT_FETCH_WORD} port_kind_t;

	typedef struct packed {
		port_kind_t             kind;
		logic [7:0]             tx_byte;
		logic [`F2H_ADDR_W-1:0] addr;
	} port_req_t;

	// Line status view, only THRE matters here
	typedef struct packed {
		logic [`F2H_DATA_W-2-`LSR_THRE_BIT:0] rsvd_hi;
		logic                                 thre;
		logic [`LSR_THRE_BIT-1:0]             rsvd_lo;
	} lsr_t;

	typedef union packed {
		logic [`F2H_DATA_W-1:0] raw;
		lsr_t                   lsr;
	} bus_word_u;

endpackage

`default_nettype wire

//--- rtl/f2h_uart_settings.svh
/* FPGA-to-HPS UART settings
   Bus widths, UART0 register map and AXI single-beat encodings */
`ifndef F2H_UART_SETTINGS_SVH
`define F2H_UART_SETTINGS_SVH

// Bridge widths
`define F2H_ADDR_W      32
`define F2H_DATA_W      32

// HPS UART0 register map
`define UART_BASE_ADDR  32'hFFC0_2000
`define UART_THR_OFS    32'h0000_0000
`define UART_LSR_OFS    32'h0000_0014
`define UART_VER_ADDR   32'hFFC0_20F8
`define LSR_THRE_BIT    5

// Every transfer is one 4-byte INCR beat
`define AXI_SIZE_WORD   3'b010
`define AXI_BURST_INCR  2'b01

`endif
